/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // word addresses seen on the host port.
    localparam logic [7:0] ADDR_GPR_BASE = 8'h00;
    localparam logic [7:0] ADDR_HI       = 8'h20;
    localparam logic [7:0] ADDR_LO       = 8'h21;
    localparam logic [7:0] ADDR_STATUS   = 8'h22;
    localparam logic [7:0] ADDR_INSTR    = 8'h30;

    // primary opcodes that carry a funct field.
    localparam logic [5:0] OPC_SPECIAL  = 6'h00;
    localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;

    localparam int MUL_CYCLES = 4;

    // signed and unsigned forms share one op, told apart by is_unsigned.
    typedef enum logic [5:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_LUI, OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO, OP_MOVN, OP_MOVZ, OP_CLO, OP_CLZ,
        OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MSUB
    } op_e;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK
    } bus_state_e;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [15:0] imm;
        logic        is_unsigned;
        logic        use_imm;
        logic        is_muldiv;
    } dec_t;

    typedef struct packed {
        logic        gpr_we;
        logic [4:0]  gpr_addr;
        logic [31:0] gpr_data;
        logic        hilo_we;
        logic [63:0] hilo_data;
        logic        ovf;
    } res_t;

endpackage

`default_nettype wire

/* rtl/mips_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_decode import mips_pkg::*; (
    input  wire [31:0] instr_i,
    output dec_t       dec_o
);

    logic [5:0] opc;
    logic [5:0] funct;

    assign opc   = instr_i[31:26];
    assign funct = instr_i[5:0];

    always_comb begin
        dec_o       = '0;
        dec_o.rs    = instr_i[25:21];
        dec_o.rt    = instr_i[20:16];
        dec_o.rd    = instr_i[15:11];
        dec_o.shamt = instr_i[10:6];
        dec_o.imm   = instr_i[15:0];
        dec_o.op    = OP_NOP;
        case (opc)
            OPC_SPECIAL: begin
                case (funct)
                    6'h00: dec_o.op = OP_SLL;
                    6'h02: dec_o.op = OP_SRL;
                    6'h03: dec_o.op = OP_SRA;
                    6'h04: dec_o.op = OP_SLLV;
                    6'h06: dec_o.op = OP_SRLV;
                    6'h07: dec_o.op = OP_SRAV;
                    6'h0a: dec_o.op = OP_MOVZ;
                    6'h0b: dec_o.op = OP_MOVN;
                    6'h10: dec_o.op = OP_MFHI;
                    6'h11: dec_o.op = OP_MTHI;
                    6'h12: dec_o.op = OP_MFLO;
                    6'h13: dec_o.op = OP_MTLO;
                    6'h18: dec_o.op = OP_MULT;
                    6'h19: dec_o.op = OP_MULTU;
                    6'h20, 6'h21: dec_o.op = OP_ADD;
                    6'h22, 6'h23: dec_o.op = OP_SUB;
                    6'h24: dec_o.op = OP_AND;
                    6'h25: dec_o.op = OP_OR;
                    6'h26: dec_o.op = OP_XOR;
                    6'h27: dec_o.op = OP_NOR;
                    6'h2a, 6'h2b: dec_o.op = OP_SLT;
                    default: dec_o.op = OP_NOP;
                endcase
            end
            OPC_SPECIAL2: begin
                case (funct)
                    6'h00: dec_o.op = OP_MADD;
                    6'h02: dec_o.op = OP_MUL;
                    6'h04: dec_o.op = OP_MSUB;
                    6'h20: dec_o.op = OP_CLZ;
                    6'h21: dec_o.op = OP_CLO;
                    default: dec_o.op = OP_NOP;
                endcase
            end
            6'h08, 6'h09: dec_o.op = OP_ADD;
            6'h0a, 6'h0b: dec_o.op = OP_SLT;
            6'h0c: dec_o.op = OP_AND;
            6'h0d: dec_o.op = OP_OR;
            6'h0e: dec_o.op = OP_XOR;
            6'h0f: dec_o.op = OP_LUI;
            default: dec_o.op = OP_NOP;
        endcase

        // every opcode in 0x08..0x0f is an immediate form.
        dec_o.use_imm = opc[5:3] == 3'b001;
        // the odd funct or opcode of each pair is the unsigned one.
        dec_o.is_unsigned = (opc == OPC_SPECIAL && funct inside {6'h19, 6'h21, 6'h23, 6'h2b})
                         || opc == 6'h09 || opc == 6'h0b;
        dec_o.is_muldiv = dec_o.op inside {OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MSUB};
    end

endmodule

`default_nettype wire

/* rtl/mips_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_muldiv import mips_pkg::*; (
    input  wire        clk,
    input  wire        rst_i,
    input  wire        start_i,
    input  wire op_e   op_i,
    input  wire [31:0] a_i,
    input  wire [31:0] b_i,
    input  wire [63:0] hilo_i,
    output logic [63:0] prod_o,
    output logic       done_o
);

    localparam int CHUNK = 32 / MUL_CYCLES;
    localparam int CW = $clog2(MUL_CYCLES + 1);

    logic [CW-1:0] cnt_q;
    logic          done_q;
    logic          neg_q;
    op_e           op_q;
    logic [63:0]   a_q;
    logic [31:0]   b_q;
    logic [63:0]   acc_q;
    logic [63:0]   mag;
    logic          is_signed;
    logic          a_neg;
    logic          b_neg;

    assign is_signed = op_i != OP_MULTU;
    assign a_neg = is_signed && a_i[31];
    assign b_neg = is_signed && b_i[31];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (start_i) begin
            cnt_q  <= CW'(MUL_CYCLES);
            done_q <= 1'b0;
        end else if (cnt_q != '0) begin
            cnt_q  <= cnt_q - 1'b1;
            done_q <= cnt_q == CW'(1);
        end
    end

    // magnitudes are multiplied one chunk of b per cycle.
    always_ff @(posedge clk) begin
        if (start_i) begin
            op_q  <= op_i;
            neg_q <= a_neg ^ b_neg;
            a_q   <= {32'b0, a_neg ? -a_i : a_i};
            b_q   <= b_neg ? -b_i : b_i;
            acc_q <= '0;
        end else if (cnt_q != '0) begin
            a_q   <= a_q << CHUNK;
            b_q   <= b_q >> CHUNK;
            acc_q <= acc_q + a_q * 64'(b_q[CHUNK-1:0]);
        end
    end

    assign mag = neg_q ? -acc_q : acc_q;

    always_comb begin
        case (op_q)
            OP_MADD: prod_o = hilo_i + mag;
            OP_MSUB: prod_o = hilo_i - mag;
            default: prod_o = mag;
        endcase
    end

    // a done left over from the last multiply must not leak into a new one.
    assign done_o = done_q && !start_i;

endmodule

`default_nettype wire

/* rtl/mips_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_execute import mips_pkg::*; (
    input  wire        clk,
    input  wire        rst_i,
    input  wire        start_i,
    input  wire dec_t  dec_i,
    input  wire [31:0] rs_val_i,
    input  wire [31:0] rt_val_i,
    input  wire [63:0] hilo_i,
    output res_t       res_o,
    output logic       done_o
);

    logic [31:0] imm_sx;
    logic [31:0] imm_zx;
    logic [31:0] opb;
    logic [31:0] sum;
    logic [31:0] diff;
    logic        add_ovf;
    logic        sub_ovf;
    logic        slt;
    logic [4:0]  sa;
    logic [63:0] prod;
    logic        mul_done;

    // leading run of bit b, 32 when the whole word matches.
    function automatic logic [31:0] lead_count(input logic [31:0] v, input logic b);
        logic [31:0] n;
        logic        run;
        n   = '0;
        run = 1'b1;
        for (int i = 31; i >= 0; i--) begin
            run = run && (v[i] == b);
            n   = n + {31'b0, run};
        end
        return n;
    endfunction

    assign imm_sx = {{16{dec_i.imm[15]}}, dec_i.imm};
    assign imm_zx = {16'b0, dec_i.imm};
    assign opb = !dec_i.use_imm ? rt_val_i :
                 (dec_i.op inside {OP_AND, OP_OR, OP_XOR}) ? imm_zx : imm_sx;

    assign sum  = rs_val_i + opb;
    assign diff = rs_val_i - opb;
    assign add_ovf = !dec_i.is_unsigned && rs_val_i[31] == opb[31] && sum[31] != rs_val_i[31];
    assign sub_ovf = !dec_i.is_unsigned && rs_val_i[31] != opb[31] && diff[31] != rs_val_i[31];
    assign slt = dec_i.is_unsigned ? rs_val_i < opb : $signed(rs_val_i) < $signed(opb);

    assign sa = (dec_i.op inside {OP_SLLV, OP_SRLV, OP_SRAV}) ? rs_val_i[4:0] : dec_i.shamt;

    assign done_o = dec_i.is_muldiv ? mul_done : 1'b1;

    mips_muldiv u_muldiv (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (start_i && dec_i.is_muldiv),
        .op_i    (dec_i.op),
        .a_i     (rs_val_i),
        .b_i     (rt_val_i),
        .hilo_i  (hilo_i),
        .prod_o  (prod),
        .done_o  (mul_done)
    );

    always_comb begin
        res_o           = '0;
        res_o.gpr_addr  = dec_i.use_imm ? dec_i.rt : dec_i.rd;
        res_o.hilo_data = hilo_i;
        res_o.gpr_we    = 1'b1;
        case (dec_i.op)
            OP_ADD: begin
                res_o.gpr_data = sum;
                res_o.ovf      = add_ovf;
                res_o.gpr_we   = !add_ovf;
            end
            OP_SUB: begin
                res_o.gpr_data = diff;
                res_o.ovf      = sub_ovf;
                res_o.gpr_we   = !sub_ovf;
            end
            OP_AND: res_o.gpr_data = rs_val_i & opb;
            OP_OR: res_o.gpr_data = rs_val_i | opb;
            OP_XOR: res_o.gpr_data = rs_val_i ^ opb;
            OP_NOR: res_o.gpr_data = ~(rs_val_i | opb);
            OP_SLT: res_o.gpr_data = {31'b0, slt};
            OP_LUI: res_o.gpr_data = {dec_i.imm, 16'b0};
            OP_SLL, OP_SLLV: res_o.gpr_data = rt_val_i << sa;
            OP_SRL, OP_SRLV: res_o.gpr_data = rt_val_i >> sa;
            OP_SRA, OP_SRAV: res_o.gpr_data = $signed(rt_val_i) >>> sa;
            OP_MFHI: res_o.gpr_data = hilo_i[63:32];
            OP_MFLO: res_o.gpr_data = hilo_i[31:0];
            OP_CLO: res_o.gpr_data = lead_count(rs_val_i, 1'b1);
            OP_CLZ: res_o.gpr_data = lead_count(rs_val_i, 1'b0);
            OP_MOVN: begin
                res_o.gpr_data = rs_val_i;
                res_o.gpr_we   = rt_val_i != 32'b0;
            end
            OP_MOVZ: begin
                res_o.gpr_data = rs_val_i;
                res_o.gpr_we   = rt_val_i == 32'b0;
            end
            OP_MTHI: begin
                res_o.gpr_we    = 1'b0;
                res_o.hilo_we   = 1'b1;
                res_o.hilo_data = {rs_val_i, hilo_i[31:0]};
            end
            OP_MTLO: begin
                res_o.gpr_we    = 1'b0;
                res_o.hilo_we   = 1'b1;
                res_o.hilo_data = {hilo_i[63:32], rs_val_i};
            end
            OP_MUL: res_o.gpr_data = prod[31:0];
            OP_MULT, OP_MULTU, OP_MADD, OP_MSUB: begin
                res_o.gpr_we    = 1'b0;
                res_o.hilo_we   = 1'b1;
                res_o.hilo_data = prod;
            end
            default: res_o.gpr_we = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mips_result.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_result import mips_pkg::*; (
    input  wire        clk,
    input  wire        rst_i,
    input  wire        commit_i,
    input  wire res_t  res_i,
    input  wire [4:0]  rs_idx_i,
    input  wire [4:0]  rt_idx_i,
    output logic [31:0] rs_val_o,
    output logic [31:0] rt_val_o,
    output logic [63:0] hilo_o,
    input  wire        host_we_i,
    input  wire [7:0]  host_addr_i,
    input  wire [31:0] host_wdata_i,
    output logic [31:0] host_rdata_o,
    input  wire        stat_clr_i
);

    logic [31:0] gpr_q [32];
    logic [31:0] hi_q;
    logic [31:0] lo_q;
    logic        ovf_q;
    logic        host_gpr;

    assign host_gpr = host_addr_i[7:5] == ADDR_GPR_BASE[7:5];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                gpr_q[i] <= '0;
            end
            hi_q  <= '0;
            lo_q  <= '0;
            ovf_q <= 1'b0;
        end else begin
            if (commit_i) begin
                // register 0 is never written.
                if (res_i.gpr_we && res_i.gpr_addr != 5'd0)
                    gpr_q[res_i.gpr_addr] <= res_i.gpr_data;
                if (res_i.hilo_we)
                    {hi_q, lo_q} <= res_i.hilo_data;
                if (res_i.ovf)
                    ovf_q <= 1'b1;
            end else if (host_we_i) begin
                if (host_gpr && host_addr_i[4:0] != 5'd0)
                    gpr_q[host_addr_i[4:0]] <= host_wdata_i;
                else if (host_addr_i == ADDR_HI)
                    hi_q <= host_wdata_i;
                else if (host_addr_i == ADDR_LO)
                    lo_q <= host_wdata_i;
            end
            if (stat_clr_i)
                ovf_q <= 1'b0;
        end
    end

    assign rs_val_o = gpr_q[rs_idx_i];
    assign rt_val_o = gpr_q[rt_idx_i];
    assign hilo_o   = {hi_q, lo_q};

    always_comb begin
        host_rdata_o = '0;
        if (host_gpr)
            host_rdata_o = gpr_q[host_addr_i[4:0]];
        else if (host_addr_i == ADDR_HI)
            host_rdata_o = hi_q;
        else if (host_addr_i == ADDR_LO)
            host_rdata_o = lo_q;
        else if (host_addr_i == ADDR_STATUS)
            host_rdata_o = {31'b0, ovf_q};
    end

endmodule

`default_nettype wire

/* rtl/mips_exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_exu_top import mips_pkg::*; (
    input  wire         clk,
    input  wire         rst_i,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wire         wb_we_i,
    input  wire [7:0]   wb_adr_i,
    input  wire [31:0]  wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);

    bus_state_e  state_q;
    logic [31:0] instr_q;
    logic        start_q;
    logic        req;
    logic        instr_req;
    logic        host_we;
    logic        stat_clr;
    logic        commit;
    logic        done;
    logic [31:0] host_rdata;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [63:0] hilo;
    dec_t        dec;
    res_t        res;

    // new requests are taken only in IDLE.
    assign req       = wb_cyc_i && wb_stb_i && state_q == IDLE;
    assign instr_req = req && wb_we_i && wb_adr_i == ADDR_INSTR;
    assign host_we   = req && wb_we_i && wb_adr_i != ADDR_INSTR;
    assign stat_clr  = req && !wb_we_i && wb_adr_i == ADDR_STATUS;
    assign commit    = state_q == EXEC && done;
    assign wb_ack_o  = state_q == ACK;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= instr_req;
            case (state_q)
                IDLE: begin
                    if (instr_req)
                        state_q <= EXEC;
                    else if (req)
                        state_q <= ACK;
                end
                EXEC: begin
                    if (done)
                        state_q <= ACK;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (instr_req)
            instr_q <= wb_dat_i;
        if (req)
            wb_dat_o <= host_rdata;
    end

    mips_decode u_decode (
        .instr_i (instr_q),
        .dec_o   (dec)
    );

    mips_execute u_execute (
        .clk      (clk),
        .rst_i    (rst_i),
        .start_i  (start_q),
        .dec_i    (dec),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .hilo_i   (hilo),
        .res_o    (res),
        .done_o   (done)
    );

    mips_result u_result (
        .clk          (clk),
        .rst_i        (rst_i),
        .commit_i     (commit),
        .res_i        (res),
        .rs_idx_i     (dec.rs),
        .rt_idx_i     (dec.rt),
        .rs_val_o     (rs_val),
        .rt_val_o     (rt_val),
        .hilo_o       (hilo),
        .host_we_i    (host_we),
        .host_addr_i  (wb_adr_i),
        .host_wdata_i (wb_dat_i),
        .host_rdata_o (host_rdata),
        .stat_clr_i   (stat_clr)
    );

endmodule

`default_nettype wire

/* test/mips_exu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_exu_chk import mips_pkg::*; (
    input wire             clk,
    input wire             rst_i,
    input wire             cyc_i,
    input wire             stb_i,
    input wire             we_i,
    input wire [7:0]       adr_i,
    input wire [31:0]      rdata_i,
    input wire             ack_i,
    input wire bus_state_e state_i,
    input wire             commit_i
);

    int err_cnt = 0;

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst_i) ack_i |=> !ack_i)
        else begin
            $error("ack held for more than one cycle");
            err_cnt++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        ack_i |-> cyc_i && stb_i)
        else begin
            $error("ack without an active request");
            err_cnt++;
        end

    // a commit belongs to an instruction write that is still held on the bus.
    commit_in_exec: assert property (@(posedge clk) disable iff (rst_i)
        commit_i |-> state_i == EXEC && cyc_i && stb_i && we_i && adr_i == ADDR_INSTR)
        else begin
            $error("commit outside of an instruction write");
            err_cnt++;
        end

    // register 0 is hardwired, so any read of it returns zero.
    reg0_zero: assert property (@(posedge clk) disable iff (rst_i)
        ack_i && !we_i && adr_i == ADDR_GPR_BASE |-> rdata_i == 32'b0)
        else begin
            $error("register 0 read back nonzero");
            err_cnt++;
        end

endmodule

bind mips_exu_top mips_exu_chk u_chk (
    .clk      (clk),
    .rst_i    (rst_i),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .we_i     (wb_we_i),
    .adr_i    (wb_adr_i),
    .rdata_i  (wb_dat_o),
    .ack_i    (wb_ack_o),
    .state_i  (state_q),
    .commit_i (commit)
);

`default_nettype wire

/* test/tb_mips_exu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exu import mips_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // reference model state.
    logic [31:0] gpr_m [32];
    logic [31:0] hi_m;
    logic [31:0] lo_m;
    logic        ovf_m;

    // logic, shift and set-less-than encodings used for random tests.
    logic [5:0] alu_functs [14] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h21,
                                    6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    logic [5:0] imm_opcodes [7] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

    mips_exu_top u_dut (
        .clk      (clk),
        .rst_i    (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset plus 300 transactions of at most 20 cycles each.
    initial begin
        repeat (16 + 300 * 20) @(posedge clk);
        $display("Watchdog expired, the bus stopped answering");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] opc, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sp2_word(input logic [5:0] funct, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd);
        return {6'h1c, rs, rt, rd, 5'd0, funct};
    endfunction

    // leading ones are counted as leading zeros of the inverted word.
    function automatic logic [31:0] count_lead(input logic [31:0] v, input logic bitval);
        logic [31:0] w;
        logic [31:0] n;
        w = bitval ? ~v : v;
        n = 32'd0;
        while (n < 32'd32 && !w[31]) begin
            w = w << 1;
            n = n + 32'd1;
        end
        return n;
    endfunction

    function automatic void ref_exec(input logic [31:0] instr);
        logic [5:0]  opc;
        logic [5:0]  funct;
        logic [4:0]  rt;
        logic [4:0]  sa;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] val;
        logic [32:0] wide;
        logic [63:0] prod;
        logic        wr;
        logic        ovf;
        opc   = instr[31:26];
        funct = instr[5:0];
        rt    = instr[20:16];
        sa    = instr[10:6];
        a     = gpr_m[instr[25:21]];
        b     = gpr_m[rt];
        simm  = {{16{instr[15]}}, instr[15:0]};
        prod  = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        dst   = instr[15:11];
        val   = 32'b0;
        wr    = 1'b1;
        ovf   = 1'b0;
        if (opc == 6'h00) begin
            case (funct)
                6'h00: val = b << sa;
                6'h02: val = b >> sa;
                6'h03: val = $signed(b) >>> sa;
                6'h04: val = b << a[4:0];
                6'h06: val = b >> a[4:0];
                6'h07: val = $signed(b) >>> a[4:0];
                6'h0a: begin
                    val = a;
                    wr  = b == 32'b0;
                end
                6'h0b: begin
                    val = a;
                    wr  = b != 32'b0;
                end
                6'h10: val = hi_m;
                6'h12: val = lo_m;
                6'h11: begin
                    hi_m = a;
                    wr   = 1'b0;
                end
                6'h13: begin
                    lo_m = a;
                    wr   = 1'b0;
                end
                6'h18: begin
                    {hi_m, lo_m} = prod;
                    wr           = 1'b0;
                end
                6'h19: begin
                    {hi_m, lo_m} = {32'b0, a} * {32'b0, b};
                    wr           = 1'b0;
                end
                6'h20, 6'h21: begin
                    wide = {a[31], a} + {b[31], b};
                    val  = wide[31:0];
                    ovf  = funct == 6'h20 && wide[32] != wide[31];
                end
                6'h22, 6'h23: begin
                    wide = {a[31], a} - {b[31], b};
                    val  = wide[31:0];
                    ovf  = funct == 6'h22 && wide[32] != wide[31];
                end
                6'h24: val = a & b;
                6'h25: val = a | b;
                6'h26: val = a ^ b;
                6'h27: val = ~(a | b);
                6'h2a: val = {31'b0, $signed(a) < $signed(b)};
                6'h2b: val = {31'b0, a < b};
                default: wr = 1'b0;
            endcase
        end else if (opc == 6'h1c) begin
            case (funct)
                6'h00: begin
                    {hi_m, lo_m} = {hi_m, lo_m} + prod;
                    wr           = 1'b0;
                end
                6'h04: begin
                    {hi_m, lo_m} = {hi_m, lo_m} - prod;
                    wr           = 1'b0;
                end
                6'h02: val = prod[31:0];
                6'h20: val = count_lead(a, 1'b0);
                6'h21: val = count_lead(a, 1'b1);
                default: wr = 1'b0;
            endcase
        end else begin
            dst = rt;
            case (opc)
                6'h08, 6'h09: begin
                    wide = {a[31], a} + {simm[31], simm};
                    val  = wide[31:0];
                    ovf  = opc == 6'h08 && wide[32] != wide[31];
                end
                6'h0a: val = {31'b0, $signed(a) < $signed(simm)};
                6'h0b: val = {31'b0, a < simm};
                6'h0c: val = a & {16'b0, instr[15:0]};
                6'h0d: val = a | {16'b0, instr[15:0]};
                6'h0e: val = a ^ {16'b0, instr[15:0]};
                6'h0f: val = {instr[15:0], 16'b0};
                default: wr = 1'b0;
            endcase
        end
        // an overflow leaves the destination alone.
        if (ovf)
            ovf_m = 1'b1;
        else if (wr && dst != 5'd0)
            gpr_m[dst] = val;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic bus_transfer(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                                output logic [31:0] rdata);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge clk);
        while (!wb_ack)
            @(negedge clk);
        rdata  = wb_dat_r;
        // the ack is taken on the next rising edge, the request drops after it.
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        bus_transfer(1'b0, adr, 32'b0, dat);
    endtask

    task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
        wb_write(ADDR_GPR_BASE | {3'b000, idx}, val);
        if (idx != 5'd0)
            gpr_m[idx] = val;
    endtask

    task automatic exec_instr(input logic [31:0] instr);
        wb_write(ADDR_INSTR, instr);
        ref_exec(instr);
    endtask

    task automatic check_reg(input logic [4:0] idx);
        logic [31:0] got;
        wb_read(ADDR_GPR_BASE | {3'b000, idx}, got);
        check_eq(got, gpr_m[idx], $sformatf("r%0d", idx));
    endtask

    task automatic check_hilo(input string what);
        logic [31:0] got;
        wb_read(ADDR_HI, got);
        check_eq(got, hi_m, {what, " hi"});
        wb_read(ADDR_LO, got);
        check_eq(got, lo_m, {what, " lo"});
    endtask

    // the read itself clears the flag.
    task automatic check_status();
        logic [31:0] got;
        wb_read(ADDR_STATUS, got);
        check_eq(got, {31'b0, ovf_m}, "status");
        ovf_m = 1'b0;
    endtask

    task automatic random_alu_test(input int count);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [3:0] k;
        logic [2:0] j;
        for (int n = 0; n < count; n++) begin
            rs = 5'($urandom_range(31, 1));
            rt = 5'($urandom_range(31, 1));
            rd = 5'($urandom_range(31, 0));
            set_reg(rs, $urandom);
            set_reg(rt, $urandom);
            if ($urandom_range(1, 0) == 0) begin
                k = 4'($urandom_range(13, 0));
                exec_instr(rtype_word(alu_functs[k], rs, rt, rd, 5'($urandom)));
                check_reg(rd);
            end else begin
                j = 3'($urandom_range(6, 0));
                exec_instr(itype_word(imm_opcodes[j], rs, rt, 16'($urandom)));
                check_reg(rt);
            end
        end
    endtask

    task automatic mul_round(input logic [31:0] x, input logic [31:0] y);
        set_reg(5'd1, x);
        set_reg(5'd2, y);
        exec_instr(rtype_word(6'h18, 5'd1, 5'd2, 5'd0, 5'd0));
        check_hilo("mult");
        exec_instr(rtype_word(6'h19, 5'd1, 5'd2, 5'd0, 5'd0));
        check_hilo("multu");
        set_reg(5'd3, $urandom);
        exec_instr(rtype_word(6'h11, 5'd3, 5'd0, 5'd0, 5'd0));
        set_reg(5'd4, $urandom);
        exec_instr(rtype_word(6'h13, 5'd4, 5'd0, 5'd0, 5'd0));
        check_hilo("mthi/mtlo");
        exec_instr(sp2_word(6'h00, 5'd1, 5'd2, 5'd0));
        check_hilo("madd");
        exec_instr(sp2_word(6'h04, 5'd1, 5'd2, 5'd0));
        check_hilo("msub");
        set_reg(5'd5, $urandom);
        exec_instr(sp2_word(6'h02, 5'd1, 5'd2, 5'd5));
        check_reg(5'd5);
        check_hilo("mul");
        exec_instr(rtype_word(6'h10, 5'd0, 5'd0, 5'd6, 5'd0));
        check_reg(5'd6);
        exec_instr(rtype_word(6'h12, 5'd0, 5'd0, 5'd7, 5'd0));
        check_reg(5'd7);
    endtask

    initial begin
        logic [31:0] v;
        void'($urandom(32'h82b5_be54));
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 8'h00;
        wb_dat_w = 32'b0;
        gpr_m    = '{default: '0};
        hi_m     = 32'b0;
        lo_m     = 32'b0;
        ovf_m    = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // register file, register 0 included.
        for (int i = 0; i < 32; i++) begin
            set_reg(5'(i), $urandom);
        end
        for (int i = 0; i < 32; i++) begin
            check_reg(5'(i));
        end
        v = $urandom;
        wb_write(ADDR_HI, v);
        hi_m = v;
        v = $urandom;
        wb_write(ADDR_LO, v);
        lo_m = v;
        check_hilo("host");

        random_alu_test(24);

        // signed overflow cases.
        set_reg(5'd1, 32'h7fff_ffff);
        set_reg(5'd2, 32'h0000_0001);
        set_reg(5'd3, 32'h1234_5678);
        exec_instr(rtype_word(6'h20, 5'd1, 5'd2, 5'd3, 5'd0));
        check_reg(5'd3);
        check_status();
        check_status();
        exec_instr(itype_word(6'h08, 5'd1, 5'd3, 16'h7fff));
        check_reg(5'd3);
        check_status();
        set_reg(5'd4, 32'h8000_0000);
        exec_instr(rtype_word(6'h22, 5'd4, 5'd2, 5'd3, 5'd0));
        check_reg(5'd3);
        check_status();
        check_status();
        exec_instr(rtype_word(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
        check_reg(5'd3);
        check_status();

        mul_round(32'h8000_0000, 32'hffff_ffff);
        mul_round(32'hffff_ffff, 32'hffff_ffff);
        mul_round($urandom, $urandom);

        for (int i = 0; i < 4; i++) begin
            set_reg(5'd9, i == 0 ? 32'h0 : i == 1 ? 32'hffff_ffff : $urandom >> (i * 7));
            exec_instr(sp2_word(6'h20, 5'd9, 5'd10, 5'd10));
            check_reg(5'd10);
            exec_instr(sp2_word(6'h21, 5'd9, 5'd11, 5'd11));
            check_reg(5'd11);
        end

        // conditional moves with rt zero, then nonzero.
        set_reg(5'd12, $urandom);
        set_reg(5'd13, 32'h0);
        set_reg(5'd14, 32'h5555_aaaa);
        exec_instr(rtype_word(6'h0b, 5'd12, 5'd13, 5'd14, 5'd0));
        check_reg(5'd14);
        exec_instr(rtype_word(6'h0a, 5'd12, 5'd13, 5'd14, 5'd0));
        check_reg(5'd14);
        set_reg(5'd13, $urandom | 32'h1);
        set_reg(5'd14, 32'h5555_aaaa);
        exec_instr(rtype_word(6'h0a, 5'd12, 5'd13, 5'd14, 5'd0));
        check_reg(5'd14);
        exec_instr(rtype_word(6'h0b, 5'd12, 5'd13, 5'd14, 5'd0));
        check_reg(5'd14);

        v = $urandom;
        exec_instr({6'h3f, v[25:0]});
        exec_instr(rtype_word(6'h05, 5'd1, 5'd2, 5'd3, 5'd0));
        exec_instr(sp2_word(6'h3f, 5'd1, 5'd2, 5'd3));
        for (int i = 0; i < 32; i++) begin
            check_reg(5'(i));
        end
        check_hilo("unknown");
        check_status();

        if (u_dut.u_chk.err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("%0d assertion failures in the bus checker", u_dut.u_chk.err_cnt);
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mips_exu.f */
rtl/mips_pkg.sv
rtl/mips_decode.sv
rtl/mips_muldiv.sv
rtl/mips_execute.sv
rtl/mips_result.sv
rtl/mips_exu_top.sv
test/mips_exu_chk.sv
test/tb_mips_exu.sv

/* Makefile */
TOP = tb_mips_exu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f mips_exu.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
